// ==== hdl/axi_rd_splt_pkg.sv ====
// Shared widths for the AXI read splitter.
// Port-0 base region and outstanding read depth.
// Address union with raw and region/offset views.

package axi_rd_splt_pkg;

  localparam int AW      = 32;
  localparam int DW      = 32;
  localparam int ID_W    = 4;
  localparam int LEN_W   = 8;
  localparam int RGN_LSB = 12;

  // Port 0 owns the 4 KiB page at zero.
  localparam logic [AW-1:0] O0_BASE_ADDR = 32'h0000_0000;

  localparam int OUTS_NUM = 4;
  // Count needs one bit more than the pointers.
  localparam int OUTS_W   = $clog2(OUTS_NUM) + 1;

  typedef struct packed {
    logic [AW-RGN_LSB-1:0] rgn;
    logic [RGN_LSB-1:0]    ofs;
  } ar_rgn_t;

  // Forwarded as raw, decoded as region/offset.
  typedef union packed {
    logic [AW-1:0] raw;
    ar_rgn_t       fld;
  } ar_addr_u;

endpackage

// ==== hdl/rd_ar_router.sv ====
// AR channel router.
// Region decode against the port-0 base, steering of valid
// and ready, order FIFO push on each accepted request.

`timescale 1ns/10ps

module rd_ar_router (
  input  logic                                 i_o0_enable,
  input  logic                                 i_s_arvalid,
  input  logic [axi_rd_splt_pkg::ID_W-1:0]     i_s_arid,
  input  axi_rd_splt_pkg::ar_addr_u            i_s_araddr,
  input  logic [axi_rd_splt_pkg::LEN_W-1:0]    i_s_arlen,
  input  logic                                 i_m0_arready,
  input  logic                                 i_m1_arready,
  input  logic                                 i_full,
  output logic                                 o_s_arready,
  output logic                                 o_m0_arvalid,
  output logic [axi_rd_splt_pkg::ID_W-1:0]     o_m0_arid,
  output logic [axi_rd_splt_pkg::AW-1:0]       o_m0_araddr,
  output logic [axi_rd_splt_pkg::LEN_W-1:0]    o_m0_arlen,
  output logic                                 o_m1_arvalid,
  output logic [axi_rd_splt_pkg::ID_W-1:0]     o_m1_arid,
  output logic [axi_rd_splt_pkg::AW-1:0]       o_m1_araddr,
  output logic [axi_rd_splt_pkg::LEN_W-1:0]    o_m1_arlen,
  output logic                                 o_push,
  output logic                                 o_push_sel
);

  import axi_rd_splt_pkg::*;

  logic rgn_match;
  logic sel_m0;
  logic sel_m1;
  logic req_ok;

  // Upper address bits against the port-0 page.
  assign rgn_match = (i_s_araddr.fld.rgn == O0_BASE_ADDR[AW-1:RGN_LSB]);
  assign sel_m0    = i_o0_enable & rgn_match;
  assign sel_m1    = ~sel_m0;

  // No new request once the order FIFO is full.
  assign req_ok = i_s_arvalid & ~i_full;

  assign o_m0_arvalid = req_ok & sel_m0;
  assign o_m1_arvalid = req_ok & sel_m1;

  assign o_s_arready = ~i_full & (sel_m1 ? i_m1_arready : i_m0_arready);

  // Payload fans out, only valid is steered.
  assign o_m0_arid   = i_s_arid;
  assign o_m0_araddr = i_s_araddr.raw;
  assign o_m0_arlen  = i_s_arlen;
  assign o_m1_arid   = i_s_arid;
  assign o_m1_araddr = i_s_araddr.raw;
  assign o_m1_arlen  = i_s_arlen;

  // Record the target port on every AR handshake.
  assign o_push     = i_s_arvalid & o_s_arready;
  assign o_push_sel = sel_m1;

endmodule

// ==== hdl/rd_order_fifo.sv ====
// Order FIFO for outstanding reads.
// Circular buffer of one-bit port selections with
// read/write pointers and an occupancy count.

`timescale 1ns/10ps

module rd_order_fifo (
  input  logic clk,
  input  logic i_rst_n,
  input  logic i_push,
  input  logic i_push_sel,
  input  logic i_pop,
  output logic o_full,
  output logic o_empty,
  output logic o_head_sel
);

  import axi_rd_splt_pkg::*;

  logic [OUTS_NUM-1:0] sel_mem;
  logic [OUTS_W-2:0]   wr_ptr;
  logic [OUTS_W-2:0]   rd_ptr;
  logic [OUTS_W-1:0]   count;

  assign o_full     = (count == OUTS_W'(OUTS_NUM));
  assign o_empty    = (count == '0);
  assign o_head_sel = sel_mem[rd_ptr];

  // Storage.
  always_ff @(posedge clk) begin
    if (i_push) begin
      sel_mem[wr_ptr] <= i_push_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        if (wr_ptr == (OUTS_W-1)'(OUTS_NUM-1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (i_pop) begin
        if (rd_ptr == (OUTS_W-1)'(OUTS_NUM-1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Simultaneous push and pop leave the count alone.
      if (i_push && !i_pop) begin
        count <= count + 1'b1;
      end else if (i_pop && !i_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== hdl/rd_ret_mux.sv ====
// R channel return mux.
// Forwards the port at the FIFO head upstream, routes
// ready back to that port, pops on the last beat.

`timescale 1ns/10ps

module rd_ret_mux (
  input  logic                              i_empty,
  input  logic                              i_head_sel,
  input  logic                              i_s_rready,
  input  logic                              i_m0_rvalid,
  input  logic [axi_rd_splt_pkg::ID_W-1:0]  i_m0_rid,
  input  logic [axi_rd_splt_pkg::DW-1:0]    i_m0_rdata,
  input  logic                              i_m0_rlast,
  input  logic                              i_m1_rvalid,
  input  logic [axi_rd_splt_pkg::ID_W-1:0]  i_m1_rid,
  input  logic [axi_rd_splt_pkg::DW-1:0]    i_m1_rdata,
  input  logic                              i_m1_rlast,
  output logic                              o_s_rvalid,
  output logic [axi_rd_splt_pkg::ID_W-1:0]  o_s_rid,
  output logic [axi_rd_splt_pkg::DW-1:0]    o_s_rdata,
  output logic                              o_s_rlast,
  output logic                              o_m0_rready,
  output logic                              o_m1_rready,
  output logic                              o_pop
);

  logic head_rvalid;
  logic fwd_en;

  // Nothing is forwarded without an outstanding read.
  assign fwd_en      = ~i_empty;
  assign head_rvalid = i_head_sel ? i_m1_rvalid : i_m0_rvalid;

  assign o_s_rvalid = fwd_en & head_rvalid;
  assign o_s_rid    = i_head_sel ? i_m1_rid   : i_m0_rid;
  assign o_s_rdata  = i_head_sel ? i_m1_rdata : i_m0_rdata;
  assign o_s_rlast  = i_head_sel ? i_m1_rlast : i_m0_rlast;

  // The port not at the head waits its turn.
  assign o_m0_rready = fwd_en & ~i_head_sel & i_s_rready;
  assign o_m1_rready = fwd_en & i_head_sel & i_s_rready;

  // Burst done.
  assign o_pop = o_s_rvalid & i_s_rready & o_s_rlast;

endmodule

// ==== hdl/axi_rd_splt.sv ====
// AXI read splitter, one master to two slave ports.
// AR router, order FIFO of target ports and R return mux.

`timescale 1ns/10ps

module axi_rd_splt (
  input  logic                                 clk,
  input  logic                                 i_rst_n,
  input  logic                                 i_o0_enable,

  input  logic                                 i_s_arvalid,
  input  logic [axi_rd_splt_pkg::ID_W-1:0]     i_s_arid,
  input  logic [axi_rd_splt_pkg::AW-1:0]       i_s_araddr,
  input  logic [axi_rd_splt_pkg::LEN_W-1:0]    i_s_arlen,
  output logic                                 o_s_arready,

  output logic                                 o_s_rvalid,
  output logic [axi_rd_splt_pkg::ID_W-1:0]     o_s_rid,
  output logic [axi_rd_splt_pkg::DW-1:0]       o_s_rdata,
  output logic                                 o_s_rlast,
  input  logic                                 i_s_rready,

  output logic                                 o_m0_arvalid,
  output logic [axi_rd_splt_pkg::ID_W-1:0]     o_m0_arid,
  output logic [axi_rd_splt_pkg::AW-1:0]       o_m0_araddr,
  output logic [axi_rd_splt_pkg::LEN_W-1:0]    o_m0_arlen,
  input  logic                                 i_m0_arready,
  input  logic                                 i_m0_rvalid,
  input  logic [axi_rd_splt_pkg::ID_W-1:0]     i_m0_rid,
  input  logic [axi_rd_splt_pkg::DW-1:0]       i_m0_rdata,
  input  logic                                 i_m0_rlast,
  output logic                                 o_m0_rready,

  output logic                                 o_m1_arvalid,
  output logic [axi_rd_splt_pkg::ID_W-1:0]     o_m1_arid,
  output logic [axi_rd_splt_pkg::AW-1:0]       o_m1_araddr,
  output logic [axi_rd_splt_pkg::LEN_W-1:0]    o_m1_arlen,
  input  logic                                 i_m1_arready,
  input  logic                                 i_m1_rvalid,
  input  logic [axi_rd_splt_pkg::ID_W-1:0]     i_m1_rid,
  input  logic [axi_rd_splt_pkg::DW-1:0]       i_m1_rdata,
  input  logic                                 i_m1_rlast,
  output logic                                 o_m1_rready
);

  logic push;
  logic push_sel;
  logic pop;
  logic full;
  logic empty;
  logic head_sel;

  rd_ar_router ar_router_i (
    .i_o0_enable  (i_o0_enable),
    .i_s_arvalid  (i_s_arvalid),
    .i_s_arid     (i_s_arid),
    .i_s_araddr   (i_s_araddr),
    .i_s_arlen    (i_s_arlen),
    .i_m0_arready (i_m0_arready),
    .i_m1_arready (i_m1_arready),
    .i_full       (full),
    .o_s_arready  (o_s_arready),
    .o_m0_arvalid (o_m0_arvalid),
    .o_m0_arid    (o_m0_arid),
    .o_m0_araddr  (o_m0_araddr),
    .o_m0_arlen   (o_m0_arlen),
    .o_m1_arvalid (o_m1_arvalid),
    .o_m1_arid    (o_m1_arid),
    .o_m1_araddr  (o_m1_araddr),
    .o_m1_arlen   (o_m1_arlen),
    .o_push       (push),
    .o_push_sel   (push_sel)
  );

  rd_order_fifo order_fifo_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_push     (push),
    .i_push_sel (push_sel),
    .i_pop      (pop),
    .o_full     (full),
    .o_empty    (empty),
    .o_head_sel (head_sel)
  );

  rd_ret_mux ret_mux_i (
    .i_empty     (empty),
    .i_head_sel  (head_sel),
    .i_s_rready  (i_s_rready),
    .i_m0_rvalid (i_m0_rvalid),
    .i_m0_rid    (i_m0_rid),
    .i_m0_rdata  (i_m0_rdata),
    .i_m0_rlast  (i_m0_rlast),
    .i_m1_rvalid (i_m1_rvalid),
    .i_m1_rid    (i_m1_rid),
    .i_m1_rdata  (i_m1_rdata),
    .i_m1_rlast  (i_m1_rlast),
    .o_s_rvalid  (o_s_rvalid),
    .o_s_rid     (o_s_rid),
    .o_s_rdata   (o_s_rdata),
    .o_s_rlast   (o_s_rlast),
    .o_m0_rready (o_m0_rready),
    .o_m1_rready (o_m1_rready),
    .o_pop       (pop)
  );

endmodule

// ==== dv/tb_rd_model.svh ====
// Reference model for the read splitter testbench.
// Routing rule, slave data rule and the in-order
// queue of expected upstream beats.

`ifndef TB_RD_MODEL_SVH
`define TB_RD_MODEL_SVH

// Expected beats as {rid, rdata, rlast}, oldest first.
logic [ID_W+DW:0] exp_q [$];

// High selects port 1.
function automatic logic route_port(input logic [AW-1:0] addr, input logic en);
  return !(en && (addr[AW-1:RGN_LSB] == O0_BASE_ADDR[AW-1:RGN_LSB]));
endfunction

// Address, beat index above bit 8, port 1 tag on top.
function automatic logic [DW-1:0] beat_data(input logic [AW-1:0] addr, input int beat,
                                            input logic port);
  logic [DW-1:0] tag;
  tag = port ? 32'hA000_0000 : 32'h0000_0000;
  return addr ^ (DW'(beat) << 8) ^ tag;
endfunction

task automatic push_expected(input logic port, input logic [ID_W-1:0] id,
                             input logic [AW-1:0] addr, input logic [LEN_W-1:0] len);
  for (int b = 0; b <= int'(len); b++) begin
    exp_q.push_back({id, beat_data(addr, b, port), b == int'(len)});
  end
endtask

task automatic report_mismatch(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
  err_cnt++;
  $display("Error: %s expected %0h actual %0h", name, exp, act);
endtask

task automatic check_beat(input logic [ID_W+DW:0] act);
  if (exp_q.size() == 0) begin
    err_cnt++;
    $display("Upstream read beat arrived with no read outstanding");
  end else begin
    if (act != exp_q[0]) report_mismatch("r_beat", 64'(exp_q[0]), 64'(act));
    exp_q.delete(0);
  end
endtask

`endif

// ==== dv/tb_axi_rd_splt.sv ====
// Testbench for the AXI read splitter.
// Master stimulus, two random slave models, routing and
// in-order return checks against the reference model.

`timescale 1ns/10ps

module tb_axi_rd_splt;

  import axi_rd_splt_pkg::*;

  // Slave burst entry {port, id, len, addr}.
  localparam int ENT_W = 1 + ID_W + LEN_W + AW;

  logic             clk;
  logic             rst_n;
  logic             o0_enable;
  logic             s_arvalid;
  logic [ID_W-1:0]  s_arid;
  logic [AW-1:0]    s_araddr;
  logic [LEN_W-1:0] s_arlen;
  logic             s_arready;
  logic             s_rvalid;
  logic [ID_W-1:0]  s_rid;
  logic [DW-1:0]    s_rdata;
  logic             s_rlast;
  logic             s_rready;
  logic [1:0]       m_arvalid;
  logic [ID_W-1:0]  m_arid [2];
  logic [AW-1:0]    m_araddr [2];
  logic [LEN_W-1:0] m_arlen [2];
  logic [1:0]       m_arready;
  logic [1:0]       m_rvalid;
  logic [ID_W-1:0]  m_rid [2];
  logic [DW-1:0]    m_rdata [2];
  logic [1:0]       m_rlast;
  logic [1:0]       m_rready;

  logic [ENT_W-1:0] pend [$];
  int               beat [2];
  logic [1:0]       r_took;
  logic             slv_hold;
  logic             bp_en;
  logic             timed_out;
  int               outs_cnt;
  int               err_cnt;
  int               rd_cnt;
  int               beat_cnt;

  `include "tb_rd_model.svh"

  axi_rd_splt dut_i (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_o0_enable  (o0_enable),
    .i_s_arvalid  (s_arvalid),
    .i_s_arid     (s_arid),
    .i_s_araddr   (s_araddr),
    .i_s_arlen    (s_arlen),
    .o_s_arready  (s_arready),
    .o_s_rvalid   (s_rvalid),
    .o_s_rid      (s_rid),
    .o_s_rdata    (s_rdata),
    .o_s_rlast    (s_rlast),
    .i_s_rready   (s_rready),
    .o_m0_arvalid (m_arvalid[0]),
    .o_m0_arid    (m_arid[0]),
    .o_m0_araddr  (m_araddr[0]),
    .o_m0_arlen   (m_arlen[0]),
    .i_m0_arready (m_arready[0]),
    .i_m0_rvalid  (m_rvalid[0]),
    .i_m0_rid     (m_rid[0]),
    .i_m0_rdata   (m_rdata[0]),
    .i_m0_rlast   (m_rlast[0]),
    .o_m0_rready  (m_rready[0]),
    .o_m1_arvalid (m_arvalid[1]),
    .o_m1_arid    (m_arid[1]),
    .o_m1_araddr  (m_araddr[1]),
    .o_m1_arlen   (m_arlen[1]),
    .i_m1_arready (m_arready[1]),
    .i_m1_rvalid  (m_rvalid[1]),
    .i_m1_rid     (m_rid[1]),
    .i_m1_rdata   (m_rdata[1]),
    .i_m1_rlast   (m_rlast[1]),
    .o_m1_rready  (m_rready[1])
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Oldest burst still owed by port p, or -1.
  function automatic int find_burst(input int p);
    for (int i = 0; i < pend.size(); i++) begin
      if (pend[i][ENT_W-1] == p[0]) return i;
    end
    return -1;
  endfunction

  // Two thirds of the addresses land in the port-0 page.
  function automatic logic [AW-1:0] rand_addr();
    logic [AW-1:0] a;
    a = $urandom;
    if ($urandom % 3 != 0) a[AW-1:RGN_LSB] = O0_BASE_ADDR[AW-1:RGN_LSB];
    return a;
  endfunction

  task automatic end_run();
    $display("Reads: %0d, beats: %0d, errors: %0d, timeouts: %0d, missing beats: %0d",
             rd_cnt, beat_cnt, err_cnt, timed_out, exp_q.size());
    if (err_cnt == 0 && !timed_out && exp_q.size() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic timeout(input string what);
    $display("Timeout while waiting for %s", what);
    timed_out = 1'b1;
    end_run();
  endtask

  // Slave stalls end after hold_for cycles; -1 keeps them.
  task automatic issue_read(input logic [AW-1:0] addr, input int hold_for);
    logic acc;
    int   t;
    s_arvalid = 1'b1;
    s_arid    = ID_W'($urandom);
    s_araddr  = addr;
    s_arlen   = LEN_W'($urandom % 4);
    acc       = 1'b0;
    for (t = 0; t < 300 && !acc; t++) begin
      @(negedge clk);
      acc = s_arready;
      @(posedge clk);
      #1;
      if (t == hold_for) slv_hold = 1'b0;
    end
    s_arvalid = 1'b0;
    if (!acc) timeout("an AR handshake");
  endtask

  task automatic wait_drain();
    int t;
    for (t = 0; t < 3000 && outs_cnt != 0; t++) begin
      @(posedge clk);
      #1;
    end
    if (outs_cnt != 0) timeout("outstanding reads to complete");
  endtask

  // Monitor at the falling edge, slaves driven after the rising edge.
  initial begin
    logic       exp_port;
    logic [1:0] exp_valid;
    int         idx;
    logic       hold_now;
    logic       bp_now;
    m_arready = 2'b00;
    m_rvalid  = 2'b00;
    m_rlast   = 2'b00;
    r_took    = 2'b00;
    s_rready  = 1'b1;
    err_cnt   = 0;
    outs_cnt  = 0;
    rd_cnt    = 0;
    beat_cnt  = 0;
    for (int p = 0; p < 2; p++) begin
      m_rid[p]   = '0;
      m_rdata[p] = '0;
      beat[p]    = 0;
    end
    forever begin
      @(negedge clk);
      hold_now = slv_hold;
      bp_now   = bp_en;
      if (rst_n) begin
        exp_port  = route_port(s_araddr, o0_enable);
        exp_valid = (s_arvalid && outs_cnt < OUTS_NUM) ? (exp_port ? 2'b10 : 2'b01) : 2'b00;
        if (m_arvalid != exp_valid) report_mismatch("ar_route", 64'(exp_valid), 64'(m_arvalid));
        if (s_arvalid && {m_arid[exp_port], m_araddr[exp_port], m_arlen[exp_port]} !=
            {s_arid, s_araddr, s_arlen}) begin
          report_mismatch("ar_payload", 64'({s_arid, s_araddr}),
                          64'({m_arid[exp_port], m_araddr[exp_port]}));
        end
        if (outs_cnt >= OUTS_NUM && s_arready) report_mismatch("ar_full", 64'(0), 64'(1));
        if (!s_rready && m_rready != 2'b00) report_mismatch("r_stall", 64'(0), 64'(m_rready));
        if (s_arvalid && s_arready) begin
          push_expected(exp_port, s_arid, s_araddr, s_arlen);
          outs_cnt++;
          rd_cnt++;
        end
        if (s_rvalid && s_rready) begin
          check_beat({s_rid, s_rdata, s_rlast});
          beat_cnt++;
          if (s_rlast) outs_cnt--;
        end
        for (int p = 0; p < 2; p++) begin
          if (m_arvalid[p] && m_arready[p]) begin
            pend.push_back({p[0], m_arid[p], m_arlen[p], m_araddr[p]});
          end
          if (m_rvalid[p] && m_rready[p]) begin
            r_took[p] = 1'b1;
            idx       = find_burst(p);
            if (m_rlast[p]) begin
              pend.delete(idx);
              beat[p] = 0;
            end else begin
              beat[p]++;
            end
          end
        end
      end
      @(posedge clk);
      #1;
      s_rready = bp_now ? (($urandom % 3) != 0) : 1'b1;
      for (int p = 0; p < 2; p++) begin
        m_arready[p] = ($urandom % 3) != 0;
        // A raised rvalid holds until its transfer.
        if (!(m_rvalid[p] && !r_took[p])) begin
          r_took[p]   = 1'b0;
          idx         = find_burst(p);
          m_rvalid[p] = (idx >= 0) && !hold_now && (($urandom % 2) == 0);
          if (idx >= 0) begin
            m_rid[p]   = pend[idx][AW+LEN_W +: ID_W];
            m_rdata[p] = beat_data(pend[idx][AW-1:0], beat[p], p[0]);
            m_rlast[p] = (beat[p] == int'(pend[idx][AW +: LEN_W]));
          end
        end
      end
    end
  end

  initial begin
    void'($urandom(19));
    rst_n     = 1'b0;
    o0_enable = 1'b1;
    s_arvalid = 1'b0;
    s_arid    = '0;
    s_araddr  = '0;
    s_arlen   = '0;
    slv_hold  = 1'b0;
    bp_en     = 1'b0;
    timed_out = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Routing and ordered return, then with upstream stalls.
    repeat (40) issue_read(rand_addr(), -1);
    bp_en = 1'b1;
    repeat (40) issue_read(rand_addr(), -1);
    wait_drain();
    o0_enable = 1'b0;
    repeat (30) issue_read(rand_addr(), -1);
    wait_drain();
    // Fill the order FIFO with stalled slaves, one more AR waits.
    o0_enable = 1'b1;
    slv_hold  = 1'b1;
    repeat (OUTS_NUM) issue_read(rand_addr(), -1);
    issue_read(rand_addr(), 20);
    wait_drain();
    end_run();
  end

endmodule

// ==== compile.f ====
+incdir+dv
hdl/axi_rd_splt_pkg.sv
hdl/rd_ar_router.sv
hdl/rd_order_fifo.sv
hdl/rd_ret_mux.sv
hdl/axi_rd_splt.sv
dv/tb_axi_rd_splt.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_axi_rd_splt
FILELIST := compile.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing -j 0 --timescale 1ns/10ps --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM_BIN  := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)
PASS_MSG := ALL TESTS PASSED

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
